// File: files.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_bram_1r1w.sv
hdl/icache_direct.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
dv/tb_memory_model.sv
dv/tb_fetch_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= tb_fetch_top
FILELIST ?= files.f

BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT := ALL CHECKS PASSED

.PHONY: sim clean

# The simulator status is masked by tee, so the log decides.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_fetch_top.sv
/* Fetch front end testbench */

`default_nettype none

`include "icache_defs.svh"

module tb_fetch_top;
	timeunit 1ns;
	timeprecision 1ps;

	import icache_pkg::*;

	localparam int SET_BITS = `ICACHE_SET_BITS;
	localparam int SETS = 1 << SET_BITS;
	localparam addr_t ALIAS_STRIDE = 32'(SETS * 4);
	localparam int DELIVERY_TIMEOUT = 200;
	// Long enough for any refill of the held pc to finish.
	localparam int SETTLE_CYCLES = 24;

	logic clock;
	logic reset;
	logic stall;
	logic redirect_valid;
	addr_t redirect_pc;
	logic instr_valid;
	word_t instr;
	addr_t instr_pc;
	logic bus_request;
	addr_t bus_address;
	logic bus_ready;
	word_t bus_rdata;
	logic [31:0] refill_count;

	// Reference model state.
	addr_t exp_pc;
	logic [31:0] exp_refills;
	int delivered;
	logic [SETS-1:0] model_valid;
	logic [`ICACHE_TAG_BITS-1:0] model_tag [SETS];
	logic [SET_BITS-1:0] line_set;
	logic [`ICACHE_TAG_BITS-1:0] line_tag;
	logic line_present;

	string test_name;
	logic [31:0] rnd_state;

	fetch_top i_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_stall(stall),
		.i_redirect_valid(redirect_valid),
		.i_redirect_pc(redirect_pc),
		.o_instr_valid(instr_valid),
		.o_instr(instr),
		.o_instr_pc(instr_pc),
		.o_bus_request(bus_request),
		.o_bus_address(bus_address),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.o_refill_count(refill_count)
	);

	tb_memory_model u_memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected memory contents at a byte address.
	function automatic word_t mem_word(input addr_t addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
	endfunction

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "Stopping at the first failure.");
	endtask

	task automatic compare_word(input word_t expected, input word_t actual, input string what);
		if (actual !== expected) begin
			$display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
			stop_run();
		end
	endtask

	task automatic verify_pc(input addr_t expected, input addr_t actual, input string what);
		if (actual !== expected) begin
			$display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
			stop_run();
		end
	endtask

	task automatic match_refills(input logic [31:0] expected, input logic [31:0] actual,
			input string what);
		if (actual !== expected) begin
			$display("** Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
			stop_run();
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// The line that the pc in flight maps to in the model.
	assign line_set = exp_pc[SET_BITS+1:2];
	assign line_tag = exp_pc[31:SET_BITS+2];
	assign line_present = model_valid[line_set] && (model_tag[line_set] == line_tag);

	// Every delivered pc is fetched into the cache, and so is the pc held
	// through the long stall before a redirect.
	always @(posedge clock) begin
		if (reset) begin
			exp_pc <= `RESET_VECTOR;
			exp_refills <= '0;
			delivered <= 0;
			model_valid <= '0;
		end else begin
			// A refill only ever asks for the word the pc stream waits on.
			if (bus_request) begin
				verify_pc(exp_pc, bus_address, "bus address");
			end
			if (redirect_valid || instr_valid) begin
				if (!line_present) begin
					model_valid[line_set] <= 1'b1;
					model_tag[line_set] <= line_tag;
					exp_refills <= exp_refills + 32'd1;
				end
				if (redirect_valid) begin
					exp_pc <= redirect_pc;
				end else begin
					verify_pc(exp_pc, instr_pc, "instruction pc");
					compare_word(mem_word(exp_pc), instr, "instruction word");
					exp_pc <= exp_pc + 32'd4;
					delivered <= delivered + 1;
				end
			end
		end
	end

	task automatic wait_deliveries(input int n);
		int target;
		int cycles;
		begin
			target = delivered + n;
			cycles = 0;
			while (delivered < target) begin
				@(negedge clock);
				cycles++;
				if (cycles > DELIVERY_TIMEOUT) begin
					$display("Timed out in %s waiting for a delivered instruction.", test_name);
					stop_run();
				end
			end
		end
	endtask

	task automatic stall_cycles(input int n);
		@(posedge clock);
		stall <= 1'b1;
		repeat (n) @(posedge clock);
		stall <= 1'b0;
		@(negedge clock);
	endtask

	// Hold the pc until its line is in, then jump and check the refill count.
	task automatic redirect_to(input addr_t target);
		@(posedge clock);
		stall <= 1'b1;
		repeat (SETTLE_CYCLES) @(posedge clock);
		redirect_valid <= 1'b1;
		redirect_pc <= target;
		@(posedge clock);
		redirect_valid <= 1'b0;
		stall <= 1'b0;
		@(negedge clock);
		match_refills(exp_refills, refill_count, "refill count");
	endtask

	initial begin
		logic [2:0] choice;
		logic [31:0] snap;
		reset <= 1'b1;
		stall <= 1'b0;
		redirect_valid <= 1'b0;
		redirect_pc <= '0;
		rnd_state = 32'h3c40_6dc7;

		test_name = "reset_clear";
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		for (int c = 0; c < SETS; c++) begin
			@(negedge clock);
			if (bus_request !== 1'b0 || instr_valid !== 1'b0) begin
				$display("Bus request or instruction seen while the cache lines were clearing.");
				stop_run();
			end
		end
		wait_deliveries(1);

		test_name = "straight_line";
		wait_deliveries(15);

		// Stop one word short so the held pc is already cached.
		test_name = "loop_second_pass";
		redirect_to(`RESET_VECTOR);
		snap = exp_refills;
		wait_deliveries(15);
		redirect_to(`RESET_VECTOR + ALIAS_STRIDE);
		match_refills(snap, refill_count, "refills after second pass");

		test_name = "conflict_redirect";
		wait_deliveries(4);
		redirect_to(`RESET_VECTOR);
		wait_deliveries(16);
		redirect_to(`RESET_VECTOR + 32'h200);

		test_name = "random_stall_redirect";
		for (int i = 0; i < 80; i++) begin
			rnd_state = lcg_next(rnd_state);
			choice = rnd_state[18:16];
			if (choice == 3'd0) begin
				// Four tags alias onto each set in this 1 KB window.
				redirect_to(`RESET_VECTOR + {22'd0, rnd_state[29:22], 2'b00});
			end else if (choice < 3'd4) begin
				stall_cycles(int'(rnd_state[21:20]) + 1);
			end else begin
				wait_deliveries(int'(rnd_state[23:22]) + 1);
			end
		end
		redirect_to(`RESET_VECTOR);
		wait_deliveries(1);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_memory_model.sv
/* Memory bus responder */

`default_nettype none

module tb_memory_model (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input icache_pkg::addr_t i_bus_address,
	output logic o_bus_ready,
	output icache_pkg::word_t o_bus_rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	import icache_pkg::*;

	logic ready_q = 1'b0;
	word_t rdata_q = '0;
	logic busy;
	logic [2:0] delay;
	logic [31:0] rnd_state;
	logic [31:0] rnd_next;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Memory contents as a function of the address.
	function automatic word_t mem_word(input addr_t addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
	endfunction

	assign rnd_next = lcg_next(rnd_state);

	// One request at a time. Ready is a one-cycle strobe.
	always @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			delay <= '0;
			ready_q <= 1'b0;
			rnd_state <= 32'h3c40_6dc7;
		end else if (ready_q) begin
			// The request is still high in this cycle and drops after it.
			ready_q <= 1'b0;
			busy <= 1'b0;
		end else if (busy) begin
			if (delay == 3'd0) begin
				ready_q <= 1'b1;
				rdata_q <= mem_word(i_bus_address);
			end else begin
				delay <= delay - 3'd1;
			end
		end else if (i_bus_request) begin
			busy <= 1'b1;
			rnd_state <= rnd_next;
			delay <= rnd_next[18:16] % 3'd6;
		end
	end

	assign o_bus_ready = ready_q;
	assign o_bus_rdata = rdata_q;

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
/* Fetch front end top level */

`default_nettype none

`include "icache_defs.svh"

module fetch_top (
	input logic i_clock,
	input logic i_reset,

	// Pipeline control.
	input logic i_stall,
	input logic i_redirect_valid,
	input icache_pkg::addr_t i_redirect_pc,

	// Delivered instruction.
	output logic o_instr_valid,
	output icache_pkg::word_t o_instr,
	output icache_pkg::addr_t o_instr_pc,

	// Memory bus.
	output logic o_bus_request,
	output icache_pkg::addr_t o_bus_address,
	input logic i_bus_ready,
	input icache_pkg::word_t i_bus_rdata,

	output logic [31:0] o_refill_count
);
	import icache_pkg::*;

	localparam int SET_BITS = `ICACHE_SET_BITS;

	// Fetch unit to cache.
	addr_t fetch_pc;
	logic cache_ready;
	word_t cache_rdata;

	// Cache to RAM.
	logic [SET_BITS-1:0] ram_rd_address;
	cache_entry_t ram_rd_data;
	logic ram_wr_enable;
	logic [SET_BITS-1:0] ram_wr_address;
	cache_entry_t ram_wr_data;

	fetch_unit u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_fetch_pc(fetch_pc),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata),
		.i_stall(i_stall),
		.i_redirect_valid(i_redirect_valid),
		.i_redirect_pc(i_redirect_pc),
		.o_instr_valid(o_instr_valid),
		.o_instr(o_instr),
		.o_instr_pc(o_instr_pc)
	);

	icache_direct #(
		.SET_BITS(SET_BITS)
	) u_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_pc(fetch_pc),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_ram_rd_address(ram_rd_address),
		.i_ram_rd_data(ram_rd_data),
		.o_ram_wr_enable(ram_wr_enable),
		.o_ram_wr_address(ram_wr_address),
		.o_ram_wr_data(ram_wr_data),
		.o_refill_count(o_refill_count)
	);

	icache_bram_1r1w #(
		.WIDTH($bits(cache_entry_t)),
		.DEPTH(1 << SET_BITS)
	) u_ram (
		.i_clock(i_clock),
		.i_rd_address(ram_rd_address),
		.o_rd_data(ram_rd_data),
		.i_wr_enable(ram_wr_enable),
		.i_wr_address(ram_wr_address),
		.i_wr_data(ram_wr_data)
	);

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
/* Instruction fetch unit */

`default_nettype none

`include "icache_defs.svh"

module fetch_unit (
	input logic i_clock,
	input logic i_reset,

	// Cache side.
	output icache_pkg::addr_t o_fetch_pc,
	input logic i_cache_ready,
	input icache_pkg::word_t i_cache_rdata,

	// Pipeline control.
	input logic i_stall,
	input logic i_redirect_valid,
	input icache_pkg::addr_t i_redirect_pc,

	// Delivered instruction.
	output logic o_instr_valid,
	output icache_pkg::word_t o_instr,
	output icache_pkg::addr_t o_instr_pc
);
	import icache_pkg::*;

	addr_t pc;
	logic take;

	// A word is taken when the cache has it and nothing holds the pc.
	assign take = i_cache_ready && !i_stall && !i_redirect_valid;

	// Redirect wins over the sequential step.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= `RESET_VECTOR;
		end else if (i_redirect_valid) begin
			pc <= {i_redirect_pc[31:2], 2'b00};
		end else if (take) begin
			pc <= pc + 32'd4;
		end
	end

	assign o_fetch_pc = pc;

	// Word goes out with the pc it was fetched from.
	assign o_instr_valid = take;
	assign o_instr = i_cache_rdata;
	assign o_instr_pc = pc;

endmodule

`default_nettype wire

// File: hdl/icache_direct.sv
/* Direct-mapped instruction cache */

`default_nettype none

`include "icache_defs.svh"

module icache_direct #(
	parameter int SET_BITS = `ICACHE_SET_BITS
)(
	input logic i_clock,
	input logic i_reset,

	// Fetch side.
	input icache_pkg::addr_t i_fetch_pc,
	output logic o_ready,
	output icache_pkg::word_t o_rdata,

	// Memory bus.
	output logic o_bus_request,
	output icache_pkg::addr_t o_bus_address,
	input logic i_bus_ready,
	input icache_pkg::word_t i_bus_rdata,

	// Line storage.
	output logic [SET_BITS-1:0] o_ram_rd_address,
	input icache_pkg::cache_entry_t i_ram_rd_data,
	output logic o_ram_wr_enable,
	output logic [SET_BITS-1:0] o_ram_wr_address,
	output icache_pkg::cache_entry_t o_ram_wr_data,

	output logic [31:0] o_refill_count
);
	import icache_pkg::*;

	localparam int TAG_BITS = 30 - SET_BITS;

	icache_state_t state;
	logic [SET_BITS-1:0] clear_set;

	logic [SET_BITS-1:0] pc_set;
	logic [TAG_BITS-1:0] pc_tag;
	logic [SET_BITS-1:0] rd_set_q;
	logic set_match;
	logic hit;
	logic miss;

	logic refill_write;
	logic refill_settle;
	logic [SET_BITS-1:0] refill_set;
	logic [TAG_BITS-1:0] refill_tag;
	word_t refill_data;

	assign pc_set = i_fetch_pc[SET_BITS+1:2];
	assign pc_tag = i_fetch_pc[31:SET_BITS+2];

	// The entry on the RAM output belongs to the set read last cycle.
	assign set_match = (rd_set_q == pc_set);

	assign hit = (state != ST_CLEAR) && set_match &&
		i_ram_rd_data.valid && (i_ram_rd_data.tag == pc_tag);

	// New refills start from lookup only, so one is in flight at a time.
	assign miss = (state == ST_LOOKUP) && set_match && !hit;

	assign o_ready = hit;
	assign o_rdata = i_ram_rd_data.data;

	// On a hit read the next set ahead for sequential code.
	always_comb begin
		if (state == ST_CLEAR) begin
			o_ram_rd_address = '0;
		end else if (hit) begin
			o_ram_rd_address = pc_set + SET_BITS'(1);
		end else begin
			o_ram_rd_address = pc_set;
		end
	end

	// Write port is shared by clearing and refill.
	always_comb begin
		o_ram_wr_enable = 1'b0;
		o_ram_wr_address = refill_set;
		o_ram_wr_data = '0;
		if (state == ST_CLEAR) begin
			o_ram_wr_enable = 1'b1;
			o_ram_wr_address = clear_set;
		end else if (refill_write) begin
			o_ram_wr_enable = 1'b1;
			o_ram_wr_data.valid = 1'b1;
			o_ram_wr_data.tag = refill_tag;
			o_ram_wr_data.data = refill_data;
		end
	end

	// Control state.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_CLEAR;
			clear_set <= '0;
			o_bus_request <= 1'b0;
			refill_write <= 1'b0;
			refill_settle <= 1'b0;
			o_refill_count <= '0;
		end else begin
			case (state)
				ST_CLEAR: begin
					clear_set <= clear_set + SET_BITS'(1);
					if (clear_set == '1) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (miss) begin
						state <= ST_REFILL;
						o_bus_request <= 1'b1;
					end
				end
				ST_REFILL: begin
					if (o_bus_request && i_bus_ready) begin
						o_bus_request <= 1'b0;
						refill_write <= 1'b1;
					end
					if (refill_write) begin
						refill_write <= 1'b0;
						refill_settle <= 1'b1;
						o_refill_count <= o_refill_count + 32'd1;
					end
					// Wait until a read of the written line has passed.
					if (refill_settle) begin
						refill_settle <= 1'b0;
						state <= ST_LOOKUP;
					end
				end
				default: begin
					state <= ST_CLEAR;
				end
			endcase
		end
	end

	// Datapath registers.
	always_ff @(posedge i_clock) begin
		rd_set_q <= o_ram_rd_address;
		if (miss) begin
			o_bus_address <= {i_fetch_pc[31:2], 2'b00};
			refill_set <= pc_set;
			refill_tag <= pc_tag;
		end
		if (o_bus_request && i_bus_ready) begin
			refill_data <= i_bus_rdata;
		end
	end

endmodule

`default_nettype wire

// File: hdl/icache_bram_1r1w.sv
/* Block RAM, one read and one write port */

`default_nettype none

module icache_bram_1r1w #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
)(
	input logic i_clock,

	// Read port with one cycle of latency.
	input logic [$clog2(DEPTH)-1:0] i_rd_address,
	output logic [WIDTH-1:0] o_rd_data,

	// Write port.
	input logic i_wr_enable,
	input logic [$clog2(DEPTH)-1:0] i_wr_address,
	input logic [WIDTH-1:0] i_wr_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Write on the clock edge.
	always_ff @(posedge i_clock) begin
		if (i_wr_enable) begin
			mem[i_wr_address] <= i_wr_data;
		end
	end

	// Registered read. It returns the old contents when the same
	// address is written in that cycle.
	always_ff @(posedge i_clock) begin
		o_rd_data <= mem[i_rd_address];
	end

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
/* Instruction fetch types */

`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

	// Instruction or data word.
	typedef logic [31:0] word_t;

	// Byte address.
	typedef logic [31:0] addr_t;

	// One cache line as stored in the block RAM.
	typedef struct packed {
		logic valid;
		logic [`ICACHE_TAG_BITS-1:0] tag;
		word_t data;
	} cache_entry_t;

	// Cache controller states.
	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_LOOKUP,
		ST_REFILL
	} icache_state_t;

endpackage

`default_nettype wire

// File: hdl/icache_defs.svh
/* Instruction cache geometry */

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Set index bits for lines of one word each.
`define ICACHE_SET_BITS 6

// Tag bits left over from a word address.
`define ICACHE_TAG_BITS (30 - `ICACHE_SET_BITS)

// Program counter after reset.
`define RESET_VECTOR 32'h0000_1000

`endif
